/* matrix_game.f */
source/matrix_game_pkg.sv
source/button_debounce.sv
source/point_mover.sv
source/background_scroller.sv
source/frame_scanner.sv
source/max7219_driver.sv
source/matrix_game_top.sv
tests/clock_gen.sv
tests/matrix_game_tb.sv

/* source/background_scroller.sv */
module background_scroller import matrix_game_pkg::*; #(
	parameter int SCROLL_TICKS = 5000000
) (
	input  logic     clock_50,
	input  logic     reset,
	input  buttons_t presses,
	output frame_t   background
);

	localparam int COUNT_W = (SCROLL_TICKS > 1) ? $clog2(SCROLL_TICKS) : 1;

	logic               running;
	logic [COUNT_W-1:0] prescaler;
	logic               scroll_tick;

	assign scroll_tick = running && (prescaler == COUNT_W'(SCROLL_TICKS - 1));

	// Game starts on the first start press and never stops
	always_ff @(posedge clock_50) begin
		if (reset) begin
			running <= 1'b0;
		end else if (presses.start) begin
			running <= 1'b1;
		end
	end

	// Prescaler only advances while running
	always_ff @(posedge clock_50) begin
		if (reset) begin
			prescaler <= '0;
		end else if (scroll_tick) begin
			prescaler <= '0;
		end else if (running) begin
			prescaler <= prescaler + 1'b1;
		end
	end

	//######################################################################
	// Background rows
	//######################################################################
	// Each row takes the one above, blank row enters at the top
	always_ff @(posedge clock_50) begin
		if (reset) begin
			background <= BACKGROUND_INIT;
		end else if (scroll_tick) begin
			background <= frame_t'({row_t'(0), background[MATRIX_SIZE-1:1]});
		end
	end

endmodule

/* source/button_debounce.sv */
module button_debounce import matrix_game_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 500000
) (
	input  logic     clock_50,
	input  logic     reset,
	input  buttons_t buttons_n,
	output buttons_t presses
);

	localparam int NUM_BUTTONS = $bits(buttons_t);
	localparam int COUNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

	logic [NUM_BUTTONS-1:0] pressed_raw;
	logic [NUM_BUTTONS-1:0] level;
	logic [NUM_BUTTONS-1:0] level_d;
	logic [COUNT_W-1:0]     count [NUM_BUTTONS];

	// Buttons pull low when pressed
	assign pressed_raw = ~buttons_n;

	// Count cycles the raw input disagrees with the stable level
	always_ff @(posedge clock_50) begin
		if (reset) begin
			level   <= '0;
			level_d <= '0;
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				count[i] <= '0;
			end
		end else begin
			level_d <= level;
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				if (pressed_raw[i] == level[i]) begin
					count[i] <= '0;
				end else if (count[i] == COUNT_W'(DEBOUNCE_CYCLES - 1)) begin
					level[i] <= pressed_raw[i];
					count[i] <= '0;
				end else begin
					count[i] <= count[i] + 1'b1;
				end
			end
		end
	end

	// One pulse per press, on the first cycle of the new level
	assign presses = level & ~level_d;

endmodule

/* source/frame_scanner.sv */
module frame_scanner import matrix_game_pkg::*; (
	input  point_pos_t point,
	input  frame_t     background,
	input  index_t     digit,
	output row_t       column
);

	frame_t point_frame;
	frame_t merged;
	index_t bit_sel;

	// One lit pixel at the point position
	always_comb begin
		point_frame = '0;
		point_frame[point.row][point.col] = 1'b1;
	end

	assign merged = point_frame | background;

	// Digit 0 drives the leftmost column
	assign bit_sel = index_t'(MATRIX_SIZE - 1) - digit;

	//######################################################################
	// Transpose into MAX7219 digit order
	//######################################################################
	// Bottom row lands in the MSB of the column byte
	always_comb begin
		for (int r = 0; r < MATRIX_SIZE; r++) begin
			column[MATRIX_SIZE-1-r] = merged[r][bit_sel];
		end
	end

endmodule

/* source/matrix_game_pkg.sv */
package matrix_game_pkg;

	// Matrix geometry
	localparam int MATRIX_SIZE = 8;

	// Bit 7 is the leftmost column
	typedef logic [MATRIX_SIZE-1:0] row_t;
	typedef logic [2:0] index_t;

	// Element 0 is the bottom row
	typedef row_t [MATRIX_SIZE-1:0] frame_t;

	typedef struct packed {
		index_t row;
		index_t col;
	} point_pos_t;

	// Raw buttons and press pulses share this layout
	typedef struct packed {
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
	} buttons_t;

	// MAX7219 serial pins
	typedef struct packed {
		logic din;
		logic ncs;
		logic clk;
	} max7219_link_t;

	// Address in the upper byte, data in the lower byte
	typedef logic [15:0] max7219_word_t;

	localparam logic [7:0] REG_DECODE_MODE  = 8'h09;
	localparam logic [7:0] REG_INTENSITY    = 8'h0A;
	localparam logic [7:0] REG_SCAN_LIMIT   = 8'h0B;
	localparam logic [7:0] REG_SHUTDOWN     = 8'h0C;
	localparam logic [7:0] REG_DISPLAY_TEST = 8'h0F;

	// Three short bars on rows 7, 4 and 2
	localparam frame_t BACKGROUND_INIT = frame_t'({8'hE0, 8'h00, 8'h00, 8'hE0,
		8'h00, 8'hE0, 8'h00, 8'h00});

	localparam point_pos_t POINT_INIT = '{row: 3'd0, col: 3'd4};

endpackage

/* source/matrix_game_top.sv */
module matrix_game_top import matrix_game_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 500000,
	parameter int SCROLL_TICKS    = 5000000,
	parameter int SPI_DIV         = 4,
	parameter int INTENSITY       = 10
) (
	input  logic          clock_50,
	input  logic          reset,
	input  buttons_t      buttons_n,
	output max7219_link_t max7219
);

	buttons_t   presses;
	point_pos_t point;
	frame_t     background;
	index_t     digit;
	row_t       column;

	//######################################################################
	// Inputs
	//######################################################################
	button_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) button_debounce_inst (
		.clock_50 (clock_50),
		.reset    (reset),
		.buttons_n(buttons_n),
		.presses  (presses)
	);

	//######################################################################
	// Game state
	//######################################################################
	point_mover point_mover_inst (
		.clock_50(clock_50),
		.reset   (reset),
		.presses (presses),
		.point   (point)
	);

	background_scroller #(
		.SCROLL_TICKS(SCROLL_TICKS)
	) background_scroller_inst (
		.clock_50  (clock_50),
		.reset     (reset),
		.presses   (presses),
		.background(background)
	);

	//######################################################################
	// Display path
	//######################################################################
	frame_scanner frame_scanner_inst (
		.point     (point),
		.background(background),
		.digit     (digit),
		.column    (column)
	);

	max7219_driver #(
		.SPI_DIV  (SPI_DIV),
		.INTENSITY(INTENSITY)
	) max7219_driver_inst (
		.clock_50(clock_50),
		.reset   (reset),
		.digit   (digit),
		.column  (column),
		.max7219 (max7219)
	);

endmodule

/* source/max7219_driver.sv */
module max7219_driver import matrix_game_pkg::*; #(
	parameter int SPI_DIV   = 4,
	parameter int INTENSITY = 10
) (
	input  logic          clock_50,
	input  logic          reset,
	output index_t        digit,
	input  row_t          column,
	output max7219_link_t max7219
);

	localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
	localparam int INIT_WORDS = 5;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_LATCH
	} state_t;

	state_t        state;
	logic [DIV_W-1:0] div_cnt;
	logic          div_last;
	logic [3:0]    bit_cnt;
	logic [2:0]    init_idx;
	logic          init_done;
	max7219_word_t shift_reg;
	max7219_word_t next_word;

	assign div_last = (div_cnt == DIV_W'(SPI_DIV - 1));

	//######################################################################
	// Word sequencer
	//######################################################################
	always_comb begin
		if (init_done) begin
			// Digit registers are addressed 1 to 8
			next_word = {{5'd0, digit} + 8'd1, column};
		end else begin
			case (init_idx)
				3'd0:    next_word = {REG_DECODE_MODE, 8'h00};
				3'd1:    next_word = {REG_INTENSITY, 8'(INTENSITY)};
				3'd2:    next_word = {REG_SCAN_LIMIT, 8'h07};
				3'd3:    next_word = {REG_SHUTDOWN, 8'h01};
				default: next_word = {REG_DISPLAY_TEST, 8'h00};
			endcase
		end
	end

	//######################################################################
	// Serial shifter and link FSM
	//######################################################################
	always_ff @(posedge clock_50) begin
		if (reset) begin
			state       <= ST_IDLE;
			div_cnt     <= '0;
			bit_cnt     <= '0;
			init_idx    <= '0;
			init_done   <= 1'b0;
			digit       <= '0;
			max7219.din <= 1'b0;
			max7219.ncs <= 1'b1;
			max7219.clk <= 1'b0;
		end else begin
			// Divider restarts on every phase step
			div_cnt <= div_last ? '0 : div_cnt + 1'b1;
			case (state)
				ST_IDLE: begin
					// Column is captured here, at word start
					if (div_last) begin
						shift_reg   <= {next_word[14:0], 1'b0};
						max7219.din <= next_word[15];
						max7219.ncs <= 1'b0;
						bit_cnt     <= '0;
						state       <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (div_last) begin
						max7219.clk <= ~max7219.clk;
						// Falling edge of clk, next bit goes out
						if (max7219.clk) begin
							if (bit_cnt == 4'd15) begin
								state <= ST_LATCH;
							end else begin
								max7219.din <= shift_reg[15];
								shift_reg   <= {shift_reg[14:0], 1'b0};
								bit_cnt     <= bit_cnt + 1'b1;
							end
						end
					end
				end
				default: begin
					// Rising ncs latches the word
					if (div_last) begin
						max7219.ncs <= 1'b1;
						max7219.din <= 1'b0;
						state       <= ST_IDLE;
						if (!init_done) begin
							if (init_idx == 3'(INIT_WORDS - 1)) begin
								init_done <= 1'b1;
							end else begin
								init_idx <= init_idx + 1'b1;
							end
						end else begin
							digit <= digit + 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

/* source/point_mover.sv */
module point_mover import matrix_game_pkg::*; (
	input  logic       clock_50,
	input  logic       reset,
	input  buttons_t   presses,
	output point_pos_t point
);

	point_pos_t point_next;
	logic       at_bottom;

	assign at_bottom = (point.row == '0);

	//######################################################################
	// Move selection, priority up, down, left, right
	//######################################################################
	always_comb begin
		point_next = point;
		if (presses.up) begin
			// Top wraps back to the bottom row
			point_next.row = point.row + 1'b1;
		end else if (presses.down) begin
			// Bottom row is a hard stop
			if (!at_bottom) begin
				point_next.row = point.row - 1'b1;
			end
		end else if (presses.left) begin
			point_next.col = point.col + 1'b1;
		end else if (presses.right) begin
			point_next.col = point.col - 1'b1;
		end
	end

	//######################################################################
	// Position register
	//######################################################################
	always_ff @(posedge clock_50) begin
		if (reset) begin
			point <= POINT_INIT;
		end else begin
			point <= point_next;
		end
	end

endmodule

/* tests/clock_gen.sv */
module clock_gen #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 10
) (
	output logic clock_50,
	output logic reset
);

	initial begin
		clock_50 = 1'b0;
		forever #(PERIOD / 2) clock_50 = ~clock_50;
	end

	// Reset spans a fixed number of rising edges
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock_50);
		reset <= 1'b0;
	end

endmodule

/* tests/matrix_game_tb.sv */
module matrix_game_tb import matrix_game_pkg::*; ();

	localparam int SCROLL_TICKS = 20000;
	localparam int WORD_TIMEOUT = 400;
	// Eight scroll periods plus a couple of sweeps of margin
	localparam int SCROLL_LIMIT = 8 * SCROLL_TICKS + 1280;
	// Rows 7 down to 0 with bars on rows 7, 4 and 2
	localparam logic [63:0] BACKGROUND_START = 64'hE000_00E0_00E0_0000;

	logic          clock_50;
	logic          reset;
	buttons_t      buttons_n;
	max7219_link_t max7219;

	max7219_word_t word_q [$];
	max7219_word_t shift_word;
	row_t          sweep_cols [MATRIX_SIZE];
	logic          prev_clk;
	logic          prev_ncs;
	int            bit_count;
	int            cycle_count = 0;

	clock_gen #(.PERIOD(8), .RESET_CYCLES(10)) clock_gen_inst (
		.clock_50(clock_50),
		.reset   (reset)
	);

	matrix_game_top #(
		.DEBOUNCE_CYCLES(4),
		.SCROLL_TICKS   (SCROLL_TICKS),
		.SPI_DIV        (2),
		.INTENSITY      (10)
	) matrix_game_top_inst (
		.clock_50 (clock_50),
		.reset    (reset),
		.buttons_n(buttons_n),
		.max7219  (max7219)
	);

	//######################################################################
	// Serial monitor that rebuilds each 16-bit word from the link pins
	//######################################################################
	always @(posedge clock_50) begin
		cycle_count <= cycle_count + 1;
		if (reset) begin
			prev_clk  <= 1'b0;
			prev_ncs  <= 1'b1;
			bit_count <= 0;
		end else begin
			prev_clk <= max7219.clk;
			prev_ncs <= max7219.ncs;
			if (!max7219.ncs && max7219.clk && !prev_clk) begin
				shift_word <= {shift_word[14:0], max7219.din};
				bit_count  <= bit_count + 1;
			end
			// Rising ncs is the latch
			if (max7219.ncs && !prev_ncs) begin
				if (bit_count != 16) begin
					$display("serial word ended after %0d bits instead of 16", bit_count);
					abort_run();
				end
				word_q.push_back(shift_word);
				bit_count <= 0;
			end
		end
	end

	task abort_run;
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic get_word(output max7219_word_t word);
		int waited;
		waited = 0;
		while (word_q.size() == 0) begin
			if (waited >= WORD_TIMEOUT) begin
				$display("no serial word received in time");
				abort_run();
			end
			@(posedge clock_50);
			waited++;
		end
		word = word_q.pop_front();
	endtask

	// Column byte for one digit takes bit 7-r from bit 7-d of row r
	function automatic row_t column_of(input logic [63:0] frame, input int digit);
		row_t col;
		for (int r = 0; r < MATRIX_SIZE; r++) begin
			col[7 - r] = frame[r * 8 + 7 - digit];
		end
		return col;
	endfunction

	// Skips to digit 1 and collects the eight columns in address order
	task automatic read_sweep(input string name);
		max7219_word_t word;
		int skipped;
		skipped = 0;
		get_word(word);
		while (word[15:8] != 8'h01) begin
			if (skipped >= 16) begin
				$display("no digit 1 word found in the serial stream");
				abort_run();
			end
			get_word(word);
			skipped++;
		end
		sweep_cols[0] = word[7:0];
		for (int d = 1; d < MATRIX_SIZE; d++) begin
			get_word(word);
			check_value({name, " address"}, 16'(d + 1), {8'h00, word[15:8]});
			sweep_cols[d] = word[7:0];
		end
	endtask

	task automatic check_frame(input string name, input logic [63:0] frame);
		for (int d = 0; d < MATRIX_SIZE; d++) begin
			check_value($sformatf("%s digit %0d", name, d + 1),
				{8'h00, column_of(frame, d)}, {8'h00, sweep_cols[d]});
		end
	endtask

	task automatic press_button(input string name);
		buttons_t held;
		held = '1;
		if (name == "start") held.start = 1'b0;
		else if (name == "up") held.up = 1'b0;
		else if (name == "down") held.down = 1'b0;
		else if (name == "left") held.left = 1'b0;
		else if (name == "right") held.right = 1'b0;
		else begin
			$display("unknown button name %s in the vector file", name);
			abort_run();
		end
		@(posedge clock_50);
		buttons_n <= held;
		repeat (10) @(posedge clock_50);
		buttons_n <= '1;
		repeat (10) @(posedge clock_50);
	endtask

	//######################################################################
	// Scroll tracking where the shift count per column may only grow
	//######################################################################
	task automatic wait_for_point_alone(input string name, input logic [63:0] target);
		int   deadline;
		int   shift;
		int   shift_start;
		logic done;
		logic found;
		deadline = cycle_count + SCROLL_LIMIT;
		shift = 0;
		done = 1'b0;
		while (!done) begin
			if (cycle_count > deadline) begin
				$display("background did not scroll off the display in time");
				abort_run();
			end
			read_sweep(name);
			done = 1'b1;
			for (int d = 0; d < MATRIX_SIZE; d++) begin
				shift_start = shift;
				found = 1'b0;
				while (!found && shift <= MATRIX_SIZE) begin
					if (column_of((BACKGROUND_START >> (8 * shift)) | target, d) == sweep_cols[d])
						found = 1'b1;
					else
						shift++;
				end
				if (!found) begin
					check_value($sformatf("%s digit %0d", name, d + 1), {8'h00,
						column_of((BACKGROUND_START >> (8 * shift_start)) | target, d)},
						{8'h00, sweep_cols[d]});
				end
				if (column_of(target, d) != sweep_cols[d]) done = 1'b0;
			end
		end
	endtask

	task automatic run_step(input string step, input string action, input string arg,
		input logic [63:0] frame);
		max7219_word_t word;
		int sweeps;
		if (action == "check") begin
			read_sweep(step);
			check_frame(step, frame);
		end else if (action == "hold") begin
			if ($sscanf(arg, "%d", sweeps) != 1) begin
				$display("hold step %s has no sweep count", step);
				abort_run();
			end
			for (int i = 0; i < sweeps; i++) begin
				read_sweep(step);
				check_frame(step, frame);
			end
		end else if (action == "press" || action == "start") begin
			if (action == "start") begin
				press_button("start");
			end else begin
				press_button(arg);
			end
			word_q.delete();
			// Word in flight may hold a column from before the move
			get_word(word);
			read_sweep(step);
			check_frame(step, frame);
		end else if (action == "wait_empty") begin
			wait_for_point_alone(step, frame);
		end else begin
			$display("unknown action %s in step %s", action, step);
			abort_run();
		end
		$display("step %s checked", step);
	endtask

	task automatic run_vectors;
		int fd;
		int count;
		string line;
		string step;
		string action;
		string arg;
		row_t row_val [MATRIX_SIZE];
		logic [63:0] frame;
		fd = $fopen("tests/matrix_game_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/matrix_game_vectors.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
				count = $sscanf(line, "%s %s %s %h %h %h %h %h %h %h %h", step, action, arg,
					row_val[7], row_val[6], row_val[5], row_val[4],
					row_val[3], row_val[2], row_val[1], row_val[0]);
				if (count != 11) begin
					$display("malformed vector line: %s", line);
					abort_run();
				end
				for (int r = 0; r < MATRIX_SIZE; r++) begin
					frame[r * 8 +: 8] = row_val[r];
				end
				run_step(step, action, arg, frame);
			end
		end
		$fclose(fd);
	endtask

	initial begin : main
		max7219_word_t word;
		max7219_word_t init_words [5];
		int waited;
		init_words = '{16'h0900, 16'h0A0A, 16'h0B07, 16'h0C01, 16'h0F00};
		buttons_n = '1;
		waited = 0;
		@(posedge clock_50);
		while (reset) begin
			if (waited > 50) begin
				$display("reset was never released");
				abort_run();
			end
			@(posedge clock_50);
			waited++;
		end
		// Setup words come first in fixed order
		for (int i = 0; i < 5; i++) begin
			get_word(word);
			check_value($sformatf("init_word%0d", i), init_words[i], word);
		end
		run_vectors();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* tests/matrix_game_vectors.txt */
# step action arg row7 row6 row5 row4 row3 row2 row1 row0
# rows are hex bytes of the merged frame, bit 7 is the left column, arg is - when unused
init_frame check - E0 00 00 E0 00 E0 00 10
hold_before_start hold 4 E0 00 00 E0 00 E0 00 10
right_to_col3 press right E0 00 00 E0 00 E0 00 08
right_to_col2 press right E0 00 00 E0 00 E0 00 04
right_to_col1 press right E0 00 00 E0 00 E0 00 02
right_to_col0 press right E0 00 00 E0 00 E0 00 01
right_wrap_to_col7 press right E0 00 00 E0 00 E0 00 80
left_wrap_to_col0 press left E0 00 00 E0 00 E0 00 01
left_to_col1 press left E0 00 00 E0 00 E0 00 02
down_stop_at_row0 press down E0 00 00 E0 00 E0 00 02
up_to_row1 press up E0 00 00 E0 00 E0 02 00
up_to_row2 press up E0 00 00 E0 00 E2 00 00
up_to_row3 press up E0 00 00 E0 02 E0 00 00
up_to_row4 press up E0 00 00 E2 00 E0 00 00
up_to_row5 press up E0 00 02 E0 00 E0 00 00
up_to_row6 press up E0 02 00 E0 00 E0 00 00
up_to_row7 press up E2 00 00 E0 00 E0 00 00
up_wrap_to_row0 press up E0 00 00 E0 00 E0 00 02
down_stop_after_wrap press down E0 00 00 E0 00 E0 00 02
start_scroll start - E0 00 00 E0 00 E0 00 02
scroll_to_point wait_empty - 00 00 00 00 00 00 00 02
